//--- ec_cfg.svh
`ifndef EC_CFG_SVH
`define EC_CFG_SVH

// coder state widths
`define EC_RANGE_WIDTH 16  // range register, normalized so bit 15 is set
`define EC_LOW_WIDTH   24  // low window, a byte plus carry above the live bits
`define EC_D_SIZE      5   // shift d and the bit counter s share this width

// symbol description widths
`define EC_PROB_WIDTH  16  // q15 cdf values fl and fh, and the boolean probability
`define EC_NSYM_WIDTH  5   // symbol count and index, up to 16 symbols
`define EC_PROB_SHIFT  6   // cdf values lose their low 6 bits before the multiply
`define EC_TERM_WIDTH  10  // EC_PROB_WIDTH - EC_PROB_SHIFT
`define EC_OFF_WIDTH   7   // 4 times a symbol count, up to 64
`define EC_MIN_PROB    4   // minimum probability given to every symbol
`define EC_CDF_TOP     32768  // an fl of this value marks the first symbol

// byte output
`define EC_BYTE_WIDTH  8
`define EC_RUN_WIDTH   8   // length of a run of 0xff bytes behind a lead byte

`endif

//--- ec_pkg.sv
package ec_pkg;

    // how a symbol is coded, selected per symbol at the input
    typedef enum logic {
        EC_KIND_CDF  = 1'b0,  // multi-symbol entry given by fl, fh and the index
        EC_KIND_BOOL = 1'b1   // single bit, its probability rides on fh
    } ec_kind_t;

    // --------------------
    // byte resolution state of the last stage
    // --------------------
    typedef enum logic {
        EMPTY = 1'b0,  // nothing held, the next pre-byte becomes the lead byte
        HELD  = 1'b1   // a lead byte and its run wait for a carry or a release
    } carry_state_t;

endpackage

//--- stage_1.sv
`include "ec_cfg.svh"

module stage_1
    import ec_pkg::*;
(
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      in_valid,
    input  ec_kind_t                  in_kind,
    input  logic [`EC_PROB_WIDTH-1:0] in_fl,
    input  logic [`EC_PROB_WIDTH-1:0] in_fh,      // also carries the boolean probability
    input  logic [`EC_NSYM_WIDTH-1:0] in_symbol,
    input  logic [`EC_NSYM_WIDTH-1:0] in_nsyms,
    input  logic                      in_bool,
    output logic                      s1_valid,
    output logic [1:0]                bool_symbol,  // [1] boolean flag, [0] value or symbol lsb
    output logic                      comp_mux_1,
    output logic [`EC_TERM_WIDTH-1:0] fl_term,
    output logic [`EC_TERM_WIDTH-1:0] fh_term,
    output logic [`EC_OFF_WIDTH-1:0]  off_u,
    output logic [`EC_OFF_WIDTH-1:0]  off_v
);

    logic                      is_bool;
    logic [`EC_NSYM_WIDTH-1:0] rem_u;  // N - s + 1 with N = nsyms - 1
    logic [`EC_NSYM_WIDTH-1:0] rem_v;  // N - s

    assign is_bool = (in_kind == EC_KIND_BOOL);
    assign rem_u   = in_nsyms - in_symbol;
    assign rem_v   = rem_u - 1'b1;

    always_ff @(posedge clk) begin
        if (reset) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= in_valid;
        end
    end

    // --------------------
    // symbol operands, loaded only when a symbol arrives
    // --------------------
    always_ff @(posedge clk) begin
        if (in_valid) begin
            bool_symbol <= {is_bool, is_bool ? in_bool : in_symbol[0]};
            // a cdf entry with fl at the top is the first symbol and needs no u
            comp_mux_1  <= !is_bool && (in_fl < `EC_CDF_TOP);
            fl_term     <= in_fl[`EC_PROB_WIDTH-1:`EC_PROB_SHIFT];
            fh_term     <= in_fh[`EC_PROB_WIDTH-1:`EC_PROB_SHIFT];
            // every symbol above the coded one keeps its own minimum share of the range
            off_u       <= is_bool ? `EC_OFF_WIDTH'(`EC_MIN_PROB) : {rem_u, 2'b00};
            off_v       <= is_bool ? `EC_OFF_WIDTH'(`EC_MIN_PROB) : {rem_v, 2'b00};
        end
    end

    // the offsets above underflow when the index falls outside its table
    sym_in_table: assert property (@(posedge clk) disable iff (reset)
        in_valid && !is_bool |-> in_symbol < in_nsyms);

endmodule

//--- stage_2.sv
`include "ec_cfg.svh"

module stage_2 (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       s1_valid,
    input  logic [1:0]                 bool_symbol,
    input  logic                       comp_mux_1,
    input  logic [`EC_TERM_WIDTH-1:0]  fl_term,
    input  logic [`EC_TERM_WIDTH-1:0]  fh_term,
    input  logic [`EC_OFF_WIDTH-1:0]   off_u,
    input  logic [`EC_OFF_WIDTH-1:0]   off_v,
    output logic                       s2_valid,
    output logic [1:0]                 bool_symbol_q,
    output logic                       comp_mux_1_q,
    output logic [`EC_RANGE_WIDTH-1:0] in_range,     // range before this symbol
    output logic [`EC_RANGE_WIDTH-1:0] range_ready,  // the held range, normalized
    output logic [`EC_RANGE_WIDTH:0]   u,
    output logic [`EC_RANGE_WIDTH:0]   v_bool,
    output logic [`EC_D_SIZE-1:0]      d
);

    localparam int PROD_W = `EC_RANGE_WIDTH - 8 + `EC_TERM_WIDTH;

    logic [PROD_W-1:0]          prod_u;     // (r >> 8) * fl_term
    logic [PROD_W-1:0]          prod_v;     // (r >> 8) * fh_term
    logic [`EC_RANGE_WIDTH:0]   u_c;
    logic [`EC_RANGE_WIDTH:0]   v_c;
    logic [`EC_RANGE_WIDTH-1:0] new_range;  // range of the coded symbol, not yet normalized
    logic [`EC_D_SIZE-1:0]      d_c;

    // only the top byte of range enters the multiply, as in the q15 reference coder
    assign prod_u = range_ready[`EC_RANGE_WIDTH-1:8] * fl_term;
    assign prod_v = range_ready[`EC_RANGE_WIDTH-1:8] * fh_term;
    assign u_c    = prod_u[PROD_W-1:1] + off_u;
    assign v_c    = prod_v[PROD_W-1:1] + off_v;

    always_comb begin
        if (bool_symbol[1]) begin
            new_range = bool_symbol[0] ? v_c[`EC_RANGE_WIDTH-1:0]
                                       : range_ready - v_c[`EC_RANGE_WIDTH-1:0];
        end else if (comp_mux_1) begin
            new_range = u_c[`EC_RANGE_WIDTH-1:0] - v_c[`EC_RANGE_WIDTH-1:0];  // [v, u) of r
        end else begin
            new_range = range_ready - v_c[`EC_RANGE_WIDTH-1:0];  // first symbol, top of r
        end
    end

    // --------------------
    // leading zero count, the highest set bit wins
    // --------------------
    always_comb begin
        d_c = '0;
        for (int i = 0; i < `EC_RANGE_WIDTH; i++) begin
            if (new_range[i]) d_c = `EC_D_SIZE'(`EC_RANGE_WIDTH - 1 - i);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            s2_valid    <= 1'b0;
            range_ready <= 16'h8000;  // coder starts at half of the full interval
        end else begin
            s2_valid <= s1_valid;
            if (s1_valid) range_ready <= new_range << d_c;  // loop closes in one cycle
        end
    end

    always_ff @(posedge clk) begin
        if (s1_valid) begin
            bool_symbol_q <= bool_symbol;
            comp_mux_1_q  <= comp_mux_1;
            in_range      <= range_ready;
            u             <= u_c;
            v_bool        <= v_c;
            d             <= d_c;
        end
    end

    // a zero range would leave bit 15 clear and stall the low update downstream
    range_norm: assert property (@(posedge clk) disable iff (reset)
        s2_valid |-> range_ready[`EC_RANGE_WIDTH-1]);

endmodule

//--- stage_3.sv
`include "ec_cfg.svh"

module stage_3 (
    input  logic [1:0]                 bool_symbol,  // [1] boolean flag, [0] value or symbol lsb
    input  logic [`EC_RANGE_WIDTH-1:0] in_range,
    input  logic [`EC_RANGE_WIDTH-1:0] range_ready,
    input  logic [`EC_D_SIZE-1:0]      d,
    input  logic                       comp_mux_1,
    input  logic [`EC_RANGE_WIDTH:0]   u,
    input  logic [`EC_RANGE_WIDTH:0]   v_bool,
    input  logic [`EC_D_SIZE-1:0]      in_s,
    input  logic [`EC_LOW_WIDTH-1:0]   in_low,
    output logic [`EC_LOW_WIDTH-1:0]   out_low,
    output logic [`EC_RANGE_WIDTH-1:0] out_range,
    output logic [`EC_BYTE_WIDTH:0]    out_bit_1,    // older pre-byte, bit 8 is its carry
    output logic [`EC_BYTE_WIDTH:0]    out_bit_2,
    output logic [1:0]                 flag_bitstream,  // 01 bit_1 only, 11 both
    output logic [`EC_D_SIZE-1:0]      out_s
);

    logic [`EC_LOW_WIDTH-1:0] low_1;       // cdf symbol above the first, low moves up by r - u
    logic [`EC_LOW_WIDTH-1:0] low_bool;
    logic [`EC_LOW_WIDTH-1:0] low;
    logic [`EC_LOW_WIDTH-1:0] m_s0, m_s8;  // masks left after one and after two bytes
    logic [`EC_LOW_WIDTH-1:0] low_s0, low_s8;
    logic [`EC_LOW_WIDTH-1:0] pre_1, pre_2;
    logic [`EC_D_SIZE-1:0]    s_comp, c_norm_s0, c_bit_s8, s_s0, s_s8;
    logic                     one_byte, two_bytes;

    assign low_1    = in_low + (in_range - u[`EC_RANGE_WIDTH-1:0]);
    assign low_bool = bool_symbol[0] ? in_low + (in_range - v_bool[`EC_RANGE_WIDTH-1:0])
                                     : in_low;  // a zero keeps the bottom part of r
    assign low      = bool_symbol[1] ? low_bool : (comp_mux_1 ? low_1 : in_low);

    // --------------------
    // normalization, s runs 9 above the reference counter so it never goes negative
    // --------------------
    assign s_comp    = in_s + d;
    assign one_byte  = (s_comp >= 5'd9) && (s_comp < 5'd17);
    assign two_bytes = (s_comp >= 5'd17);

    assign c_norm_s0 = in_s + 5'd7;   // position of the first byte inside low
    assign c_bit_s8  = in_s - 5'd1;   // and of the second, one byte lower
    assign m_s0      = (24'd1 << c_norm_s0) - 24'd1;
    assign m_s8      = m_s0 >> 8;
    assign low_s0    = low & m_s0;
    assign low_s8    = low_s0 & m_s8;
    assign s_s0      = s_comp - 5'd8;    // each byte rewinds the counter by 8
    assign s_s8      = s_comp - 5'd16;

    assign pre_1 = low >> c_norm_s0;  // nine bits remain, the byte and its carry
    assign pre_2 = low_s0 >> c_bit_s8;

    // --------------------
    // outputs
    // --------------------
    assign out_range = range_ready;
    assign out_low   = two_bytes ? low_s8 << d : (one_byte ? low_s0 << d : low << d);
    assign out_s     = two_bytes ? s_s8 : (one_byte ? s_s0 : s_comp);

    assign out_bit_1      = (one_byte || two_bytes) ? pre_1[`EC_BYTE_WIDTH:0] : '0;
    assign out_bit_2      = two_bytes ? pre_2[`EC_BYTE_WIDTH:0] : '0;
    assign flag_bitstream = two_bytes ? 2'b11 : (one_byte ? 2'b01 : 2'b00);

    // a third byte, the missing flag value 10, needs s above 8 or a shift above 15
    always_comb begin
        assert ($isunknown({in_s, d}) || (in_s < 5'd9 && d < 5'd16))
            else $error("stage_3 bit counter or shift out of range");
    end

endmodule

//--- stage_4.sv
`include "ec_cfg.svh"

module stage_4
    import ec_pkg::*;
(
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      s2_valid,
    input  logic [`EC_LOW_WIDTH-1:0]  out_low,
    input  logic [`EC_D_SIZE-1:0]     out_s,
    input  logic [`EC_BYTE_WIDTH:0]   out_bit_1,
    input  logic [`EC_BYTE_WIDTH:0]   out_bit_2,
    input  logic [1:0]                flag_bitstream,
    input  logic                      flush,
    output logic [`EC_LOW_WIDTH-1:0]  low_q,
    output logic [`EC_D_SIZE-1:0]     s_q,
    output logic                      ev_valid_1,
    output logic [`EC_BYTE_WIDTH-1:0] ev_byte_1,
    output logic [`EC_RUN_WIDTH-1:0]  ev_run_1,
    output logic                      ev_carry_1,
    output logic                      ev_valid_2,
    output logic [`EC_BYTE_WIDTH-1:0] ev_byte_2,
    output logic [`EC_RUN_WIDTH-1:0]  ev_run_2,
    output logic                      ev_carry_2
);

    carry_state_t              st_q, st_c;
    logic [`EC_BYTE_WIDTH-1:0] lead_q, lead_c;  // held lead byte
    logic [`EC_RUN_WIDTH-1:0]  run_q, run_c;    // 0xff bytes queued behind it
    logic                      rel_a, rel_b, rel_f;
    logic [`EC_BYTE_WIDTH-1:0] byte_a, byte_b;
    logic [`EC_RUN_WIDTH-1:0]  run_a, run_b;
    logic                      carry_a, carry_b;

    // resolve one pre-byte against the held event
    // a carry can reach a held event only once, so that event is final right away
    function automatic void take_byte(
        input  logic                      en,
        input  logic [`EC_BYTE_WIDTH:0]   pre,
        inout  carry_state_t              st,
        inout  logic [`EC_BYTE_WIDTH-1:0] lead,
        inout  logic [`EC_RUN_WIDTH-1:0]  run,
        output logic                      rel,
        output logic [`EC_BYTE_WIDTH-1:0] rel_byte,
        output logic [`EC_RUN_WIDTH-1:0]  rel_run,
        output logic                      rel_carry
    );
        rel       = 1'b0;
        rel_byte  = lead + `EC_BYTE_WIDTH'(pre[`EC_BYTE_WIDTH]);  // carry lands on the lead
        rel_run   = run;
        rel_carry = pre[`EC_BYTE_WIDTH];  // the 0xff run rolls over to zeros
        if (en) begin
            if (st == HELD && pre[`EC_BYTE_WIDTH]) begin
                rel  = 1'b1;
                lead = pre[`EC_BYTE_WIDTH-1:0];
                run  = '0;
            end else if (st == HELD && pre[`EC_BYTE_WIDTH-1:0] == 8'hff) begin
                run = run + 1'b1;  // may still take a carry, keep it waiting
            end else begin
                rel  = (st == HELD);  // with nothing held a stray carry is dropped
                st   = HELD;
                lead = pre[`EC_BYTE_WIDTH-1:0];
                run  = '0;
            end
        end
    endfunction

    always_comb begin
        st_c   = st_q;
        lead_c = lead_q;
        run_c  = run_q;
        take_byte(s2_valid && flag_bitstream[0], out_bit_1, st_c, lead_c, run_c,
                  rel_a, byte_a, run_a, carry_a);
        take_byte(s2_valid && flag_bitstream[1], out_bit_2, st_c, lead_c, run_c,
                  rel_b, byte_b, run_b, carry_b);
        rel_f = flush && (st_c == HELD);  // flush goes last, after this cycle's bytes
        if (flush) st_c = EMPTY;
    end

    // --------------------
    // coder state and event strobes
    // --------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            low_q      <= '0;
            s_q        <= '0;
            st_q       <= EMPTY;
            ev_valid_1 <= 1'b0;
            ev_valid_2 <= 1'b0;
        end else begin
            if (s2_valid) begin
                low_q <= out_low;  // fed back to stage_3 for the next symbol
                s_q   <= out_s;
            end
            st_q       <= st_c;
            ev_valid_1 <= rel_a | rel_b | rel_f;
            ev_valid_2 <= (rel_a & rel_b) | ((rel_a | rel_b) & rel_f);
        end
    end

    // lane 1 takes the oldest release, lane 2 the next one
    always_ff @(posedge clk) begin
        lead_q     <= lead_c;
        run_q      <= run_c;
        ev_byte_1  <= rel_a ? byte_a : (rel_b ? byte_b : lead_c);
        ev_run_1   <= rel_a ? run_a : (rel_b ? run_b : run_c);
        ev_carry_1 <= rel_a ? carry_a : (rel_b & carry_b);
        ev_byte_2  <= (rel_a & rel_b) ? byte_b : lead_c;
        ev_run_2   <= (rel_a & rel_b) ? run_b : run_c;
        ev_carry_2 <= rel_a & rel_b & carry_b;
    end

    // one more 0xff byte would wrap the run and lose 256 bytes
    run_no_wrap: assert property (@(posedge clk) disable iff (reset)
        st_q == HELD |-> run_q != '1);

    // two lanes only cover a flush that does not meet a two-byte symbol
    lanes_fit: assert property (@(posedge clk) disable iff (reset)
        !(rel_a && rel_b && rel_f));

endmodule

//--- ec_encoder_top.sv
`include "ec_cfg.svh"

module ec_encoder_top
    import ec_pkg::*;
(
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      in_valid,
    input  ec_kind_t                  in_kind,
    input  logic [`EC_PROB_WIDTH-1:0] in_fl,
    input  logic [`EC_PROB_WIDTH-1:0] in_fh,      // boolean probability for EC_KIND_BOOL
    input  logic [`EC_NSYM_WIDTH-1:0] in_symbol,
    input  logic [`EC_NSYM_WIDTH-1:0] in_nsyms,
    input  logic                      in_bool,
    input  logic                      flush,
    output logic                      ev_valid_1,  // lane 1 is always the older event
    output logic [`EC_BYTE_WIDTH-1:0] ev_byte_1,
    output logic [`EC_RUN_WIDTH-1:0]  ev_run_1,
    output logic                      ev_carry_1,
    output logic                      ev_valid_2,
    output logic [`EC_BYTE_WIDTH-1:0] ev_byte_2,
    output logic [`EC_RUN_WIDTH-1:0]  ev_run_2,
    output logic                      ev_carry_2
);

    // --------------------
    // stage 1 to stage 2
    // --------------------
    logic                       s1_valid, comp_mux_1;
    logic [1:0]                 bool_symbol;
    logic [`EC_TERM_WIDTH-1:0]  fl_term, fh_term;
    logic [`EC_OFF_WIDTH-1:0]   off_u, off_v;

    // stage 2 to stage 3
    logic                       s2_valid, comp_mux_1_q;
    logic [1:0]                 bool_symbol_q;
    logic [`EC_RANGE_WIDTH-1:0] in_range, range_ready;
    logic [`EC_RANGE_WIDTH:0]   u, v_bool;
    logic [`EC_D_SIZE-1:0]      d;

    // stage 3 to stage 4, and the low/s loop back
    logic [`EC_LOW_WIDTH-1:0]   out_low, low_q;
    logic [`EC_D_SIZE-1:0]      out_s, s_q;
    logic [`EC_BYTE_WIDTH:0]    out_bit_1, out_bit_2;
    logic [1:0]                 flag_bitstream;

    stage_1 i_stage_1 (
        .clk, .reset, .in_valid, .in_kind, .in_fl, .in_fh, .in_symbol, .in_nsyms, .in_bool,
        .s1_valid, .bool_symbol, .comp_mux_1, .fl_term, .fh_term, .off_u, .off_v
    );

    stage_2 i_stage_2 (
        .clk, .reset, .s1_valid, .bool_symbol, .comp_mux_1, .fl_term, .fh_term,
        .off_u, .off_v, .s2_valid, .bool_symbol_q, .comp_mux_1_q, .in_range,
        .range_ready, .u, .v_bool, .d
    );

    // the range is already held in stage_2, so out_range stays open here
    stage_3 i_stage_3 (
        .bool_symbol(bool_symbol_q), .in_range, .range_ready, .d,
        .comp_mux_1(comp_mux_1_q), .u, .v_bool, .in_s(s_q), .in_low(low_q),
        .out_low, .out_range(), .out_bit_1, .out_bit_2, .flag_bitstream, .out_s
    );

    stage_4 i_stage_4 (
        .clk, .reset, .s2_valid, .out_low, .out_s, .out_bit_1, .out_bit_2,
        .flag_bitstream, .flush, .low_q, .s_q,
        .ev_valid_1, .ev_byte_1, .ev_run_1, .ev_carry_1,
        .ev_valid_2, .ev_byte_2, .ev_run_2, .ev_carry_2
    );

endmodule

//--- tb_ec_encoder.sv
`include "ec_cfg.svh"

module tb_ec_encoder
    import ec_pkg::*;
();

    // --------------------
    // test lengths, the watchdog is derived from them
    // --------------------
    localparam int N_FIRST   = 8;
    localparam int N_BOOL    = 400;
    localparam int N_CDF     = 400;
    localparam int N_SKEW    = 600;
    localparam int N_BURSTS  = 6;
    localparam int BURST_MAX = 100;
    localparam longint LIMIT = 100 * ((0 + 20) + (N_FIRST + 20) + (N_BOOL + 20) +
                               (N_CDF + 20) + (N_SKEW + 20) + N_BURSTS * (BURST_MAX + 20));

    logic                      clk;
    logic                      reset;
    logic                      in_valid;
    ec_kind_t                  in_kind;
    logic [`EC_PROB_WIDTH-1:0] in_fl;
    logic [`EC_PROB_WIDTH-1:0] in_fh;
    logic [`EC_NSYM_WIDTH-1:0] in_symbol;
    logic [`EC_NSYM_WIDTH-1:0] in_nsyms;
    logic                      in_bool;
    logic                      flush;
    logic                      ev_valid_1, ev_valid_2;
    logic [`EC_BYTE_WIDTH-1:0] ev_byte_1, ev_byte_2;
    logic [`EC_RUN_WIDTH-1:0]  ev_run_1, ev_run_2;
    logic                      ev_carry_1, ev_carry_2;

    // reference coder state, libaom style with cnt starting at -9
    int unsigned m_rng;
    int unsigned m_low;
    int          m_cnt;
    int          pre_q[$];   // 9-bit pre-bytes of the current burst, carry in bit 8
    int          exp_q[$];   // resolved bytes the DUT must produce
    int          dut_q[$];   // DUT events expanded into bytes
    int          cdf_tab[16];
    longint      total_bytes;

    ec_encoder_top i_dut (
        .clk, .reset, .in_valid, .in_kind, .in_fl, .in_fh, .in_symbol, .in_nsyms,
        .in_bool, .flush,
        .ev_valid_1, .ev_byte_1, .ev_run_1, .ev_carry_1,
        .ev_valid_2, .ev_byte_2, .ev_run_2, .ev_carry_2
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;  // period of 100
    end

    initial begin
        #(LIMIT);
        $display("timeout: the encoder tests did not finish in %0d time units", LIMIT);
        $display("** FAIL **");
        $fatal(1, "watchdog expired");
    end

    task automatic check_equal(input longint actual, input longint expected,
                               input string what);
        if (actual !== expected) begin
            $display("[ERROR] %0t: %s, got %0h expected %0h", $time, what, actual, expected);
            $display("** FAIL **");
            $fatal(1, "mismatch");
        end
    endtask

    // --------------------
    // reference model of the q15 range coder
    // --------------------
    function automatic void model_encode(input bit is_bool, input int fl, input int fh,
                                         input int sym, input int nsyms, input bit val);
        int unsigned r_top;
        int unsigned u;
        int unsigned v;
        int unsigned new_r;
        int unsigned low;
        int          n;
        int          d;
        int          c;
        int          s;
        r_top = m_rng >> 8;
        low   = m_low;
        if (is_bool) begin
            v = ((r_top * (fh >> 6)) >> 1) + `EC_MIN_PROB;
            if (val) begin
                low   = m_low + m_rng - v;  // a one takes the top part of the interval
                new_r = v;
            end else begin
                new_r = m_rng - v;
            end
        end else begin
            n = nsyms - 1;
            u = ((r_top * (fl >> 6)) >> 1) + `EC_MIN_PROB * (n - sym + 1);
            v = ((r_top * (fh >> 6)) >> 1) + `EC_MIN_PROB * (n - sym);
            if (fl < `EC_CDF_TOP) begin
                low   = m_low + m_rng - u;
                new_r = u - v;
            end else begin
                new_r = m_rng - v;  // first symbol sits at the top
            end
        end
        low = low & 32'hff_ffff;
        d = 0;
        while (d < 16 && ((new_r << d) & 32'h8000) == 0) d++;
        c = m_cnt;
        s = c + d;
        if (s >= 0) begin
            c += 16;
            if (s >= 8) begin
                pre_q.push_back((low >> c) & 32'h1ff);
                low = low & ((32'd1 << c) - 1);
                c -= 8;
            end
            pre_q.push_back((low >> c) & 32'h1ff);
            low = low & ((32'd1 << c) - 1);
            s = c + d - 24;
        end
        m_low = (low << d) & 32'hff_ffff;
        m_rng = (new_r << d) & 32'hffff;
        m_cnt = s;
    endfunction

    // carries run backwards through the burst, one left over at its start is lost
    function automatic void resolve_burst();
        int tmp[$];
        int c;
        c = 0;
        tmp = pre_q;
        for (int i = pre_q.size() - 1; i >= 0; i--) begin
            c = pre_q[i] + c;
            tmp[i] = c & 8'hff;
            c = c >> 8;
        end
        foreach (tmp[i]) exp_q.push_back(tmp[i]);
        pre_q.delete();
    endfunction

    // --------------------
    // stimulus
    // --------------------
    task automatic drive_symbol(input bit is_bool, input int fl, input int fh,
                                input int sym, input int nsyms, input bit val);
        @(negedge clk);
        in_valid  = 1'b1;
        in_kind   = is_bool ? EC_KIND_BOOL : EC_KIND_CDF;
        in_fl     = fl[15:0];
        in_fh     = fh[15:0];
        in_symbol = sym[4:0];
        in_nsyms  = nsyms[4:0];
        in_bool   = val;
        model_encode(is_bool, fl, fh, sym, nsyms, val);
    endtask

    task automatic send_bool(input bit val, input int f);
        drive_symbol(1'b1, 0, f, 0, 2, val);
    endtask

    // random descending icdf table, at least 64 between entries, last entry 0
    task automatic send_cdf();
        int n;
        int sym;
        int prev;
        int rem;
        int max_step;
        n = 2 + $urandom % 15;
        prev = `EC_CDF_TOP;
        for (int i = 0; i < n - 1; i++) begin
            rem = n - 1 - i;
            max_step = prev / rem;
            prev = prev - (64 + $urandom % (max_step - 63));
            cdf_tab[i] = prev;
        end
        cdf_tab[n-1] = 0;
        sym = $urandom % n;
        drive_symbol(1'b0, (sym == 0) ? `EC_CDF_TOP : cdf_tab[sym-1], cdf_tab[sym],
                     sym, n, 1'b0);
    endtask

    task automatic send_random();
        if ($urandom % 2) send_bool($urandom % 2, $urandom % 32768);
        else send_cdf();
    endtask

    // four quiet cycles, a one-cycle flush, then the queues must agree
    task automatic flush_and_compare(input string what);
        int n;
        @(negedge clk);
        in_valid = 1'b0;
        repeat (3) @(negedge clk);
        flush = 1'b1;
        @(negedge clk);
        flush = 1'b0;
        repeat (2) @(negedge clk);
        resolve_burst();
        n = (exp_q.size() < dut_q.size()) ? exp_q.size() : dut_q.size();
        for (int i = 0; i < n; i++) begin
            check_equal(dut_q[i], exp_q[i], $sformatf("%s byte %0d", what, i));
        end
        check_equal(dut_q.size(), exp_q.size(), {what, " byte count"});
        total_bytes += exp_q.size();
        exp_q.delete();
        dut_q.delete();
    endtask

    // --------------------
    // event monitor, outputs are sampled away from the rising edge
    // --------------------
    task automatic expand_event(input logic [7:0] lead, input logic [7:0] run,
                                input logic carry);
        dut_q.push_back(lead);
        for (int k = 0; k < run; k++) dut_q.push_back(carry ? 8'h00 : 8'hff);
    endtask

    always @(negedge clk) begin
        if (!reset) begin
            if (ev_valid_1) expand_event(ev_byte_1, ev_run_1, ev_carry_1);  // older lane first
            if (ev_valid_2) expand_event(ev_byte_2, ev_run_2, ev_carry_2);
        end
    end

    initial begin
        int long_left;
        int mix_left;
        int len;
        reset     = 1'b1;
        in_valid  = 1'b0;
        in_kind   = EC_KIND_CDF;
        in_fl     = '0;
        in_fh     = '0;
        in_symbol = '0;
        in_nsyms  = 5'd2;
        in_bool   = 1'b0;
        flush     = 1'b0;
        total_bytes = 0;
        m_rng = 32'h8000;
        m_low = 0;
        m_cnt = -9;
        void'($urandom(32'haf89));
        repeat (3) @(negedge clk);
        reset = 1'b0;

        // quiet after reset, and a flush with nothing held stays quiet
        for (int i = 0; i < 6; i++) begin
            @(negedge clk);
            flush = (i == 2);
            check_equal(ev_valid_1, 0, "ev_valid_1 while idle");
            check_equal(ev_valid_2, 0, "ev_valid_2 while idle");
        end
        flush = 1'b0;
        check_equal(dut_q.size(), 0, "bytes while idle");

        for (int i = 0; i < N_FIRST; i++) send_random();
        flush_and_compare("first burst");

        for (int i = 0; i < N_BOOL; i++) send_bool($urandom % 2, $urandom % 32768);
        flush_and_compare("boolean");

        for (int i = 0; i < N_CDF; i++) send_cdf();
        flush_and_compare("cdf");

        // improbable ones fill bytes with ones, probable ones and random ones break the runs
        long_left = 0;
        mix_left  = 0;
        for (int i = 0; i < N_SKEW; i++) begin
            if (long_left == 0 && mix_left == 0) begin
                long_left = 8 + $urandom % 33;
                mix_left  = 1 + $urandom % 5;
            end
            if (long_left > 0) begin
                send_bool(1'b1, 64 + $urandom % 192);
                long_left--;
            end else begin
                if ($urandom % 2) send_bool(1'b1, 31000 + $urandom % 1768);
                else send_random();
                mix_left--;
            end
        end
        flush_and_compare("skewed");

        for (int b = 0; b < N_BURSTS; b++) begin
            len = BURST_MAX / 2 + $urandom % (BURST_MAX / 2 + 1);
            for (int i = 0; i < len; i++) send_random();
            flush_and_compare($sformatf("burst %0d", b));
        end

        if (total_bytes > 0) begin
            $display("total bytes checked: %0d", total_bytes);
            $display("** PASS **");
        end else begin
            $display("no bytes were checked");
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

//--- all.f
+incdir+.
ec_pkg.sv
stage_1.sv
stage_2.sv
stage_3.sv
stage_4.sv
ec_encoder_top.sv
tb_ec_encoder.sv

//--- Makefile
# Verilator simulation of the range encoder

SIM = obj_dir/Vtb_ec_encoder

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build and run the testbench, fail unless the pass line is in sim.log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

$(SIM): all.f *.sv *.svh
	verilator --binary --timing --assert -Wno-fatal -f all.f --top-module tb_ec_encoder

test: $(SIM)
	./$(SIM) | tee sim.log
	@grep -qx '\*\* PASS \*\*' sim.log

clean:
	rm -rf obj_dir sim.log
